// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -Wno-fatal \
		--top-module tb_keccak_sponge -Mdir obj_dir -f keccak_sponge_top.f

run: compile
	-./obj_dir/Vtb_keccak_sponge > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== common/keccak_pkg.sv ====
package keccak_pkg;

  ////////////////////////////////////////
  // Keccak-f[200] geometry
  ////////////////////////////////////////

  localparam int state_w    = 200;
  localparam int lane_w     = 8;
  // 12 + 2*log2(lane width)
  localparam int num_rounds = 12 + 2 * $clog2(lane_w);
  localparam int rnd_w      = 5;

  // Lane (x,y) lives at bits [lane_w*(5y+x) +: lane_w]
  typedef logic [state_w-1:0] keccak_state_t;

  // Iota constants, low byte of the 64-bit Keccak table
  function automatic logic [lane_w-1:0] round_const(input logic [rnd_w-1:0] rnd);
    case (rnd)
      5'd0:    return 8'h01;
      5'd1:    return 8'h82;
      5'd2:    return 8'h8a;
      5'd3:    return 8'h00;
      5'd4:    return 8'h8b;
      5'd5:    return 8'h01;
      5'd6:    return 8'h81;
      5'd7:    return 8'h09;
      5'd8:    return 8'h8a;
      5'd9:    return 8'h88;
      5'd10:   return 8'h09;
      5'd11:   return 8'h0a;
      5'd12:   return 8'h8b;
      5'd13:   return 8'h8b;
      5'd14:   return 8'h89;
      5'd15:   return 8'h03;
      5'd16:   return 8'h02;
      5'd17:   return 8'h80;
      default: return 8'h00;
    endcase
  endfunction

  // Rho offsets indexed by 5y+x, folded to the lane width
  function automatic int rot_offset(input int idx);
    int offs [25];
    offs = '{0, 1, 62, 28, 27, 36, 44, 6, 55, 20, 3, 10, 43, 25, 39,
             41, 45, 15, 21, 8, 18, 2, 61, 56, 14};
    return offs[idx] % lane_w;
  endfunction

  ////////////////////////////////////////
  // Host command
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    op_absorb  = 2'd0,
    op_squeeze = 2'd1,
    op_clear   = 2'd2
  } sponge_op_e;

  typedef struct packed {
    sponge_op_e    op;
    keccak_state_t block;
  } sponge_cmd_t;

endpackage

// ==== keccak_round/keccak_perm_step.sv ====
`timescale 1ns/1ns

module keccak_perm_step (
  input  logic [keccak_pkg::rnd_w-1:0] rnd_i,
  input  keccak_pkg::keccak_state_t    s_i,
  output keccak_pkg::keccak_state_t    s_o
);
  import keccak_pkg::*;

  typedef logic [lane_w-1:0] lane_t;

  // Lane arrays between the step mappings
  lane_t a_in  [25];
  lane_t theta [25];
  lane_t pi_b  [25];
  lane_t chi   [25];
  // Column parities and theta effect
  lane_t col_c [5];
  lane_t col_d [5];

  // Left rotate inside one lane
  function automatic lane_t rotl(input lane_t v, input int n);
    return (v << n) | (v >> (lane_w - n));
  endfunction

  ////////////////////////////////////////
  // Theta
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 25; i++) begin
      a_in[i] = s_i[lane_w*i +: lane_w];
    end
    for (int x = 0; x < 5; x++) begin
      col_c[x] = a_in[x] ^ a_in[x+5] ^ a_in[x+10] ^ a_in[x+15] ^ a_in[x+20];
    end
    // Left neighbour plus rotated right neighbour
    for (int x = 0; x < 5; x++) begin
      col_d[x] = col_c[(x+4)%5] ^ rotl(col_c[(x+1)%5], 1);
    end
    for (int i = 0; i < 25; i++) begin
      theta[i] = a_in[i] ^ col_d[i%5];
    end
  end

  ////////////////////////////////////////
  // Rho, pi, chi and iota
  ////////////////////////////////////////

  // Lane (x,y) moves to (y, 2x+3y) after its rotation
  always_comb begin
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        pi_b[5*((2*x+3*y)%5) + y] = rotl(theta[5*y+x], rot_offset(5*y+x));
      end
    end
  end

  always_comb begin
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        chi[5*y+x] = pi_b[5*y+x] ^ (~pi_b[5*y+(x+1)%5] & pi_b[5*y+(x+2)%5]);
      end
    end
    // Round constant only touches lane 0
    chi[0] = chi[0] ^ round_const(rnd_i);
    for (int i = 0; i < 25; i++) begin
      s_o[lane_w*i +: lane_w] = chi[i];
    end
  end

endmodule

// ==== keccak_round/keccak_round.sv ====
`timescale 1ns/1ns

module keccak_round (
  input  logic                      clk_i,
  input  logic                      rst_b,
  input  logic                      run_i,
  input  logic                      squeeze_i,
  input  logic                      clear_i,
  input  keccak_pkg::keccak_state_t data_i,
  output logic                      ready_o,
  output logic                      complete_o,
  output keccak_pkg::keccak_state_t state_o
);
  import keccak_pkg::*;

  typedef enum logic {
    st_idle,
    st_active
  } round_st_e;

  round_st_e st_q;
  round_st_e st_d;

  // Control strobes from the FSM
  logic update_storage;
  logic xor_message;
  logic rst_storage;
  logic inc_rnd;
  logic rst_rnd;
  logic rnd_eq_end;
  // Registered into complete_o one cycle later
  logic complete_d;

  logic [rnd_w-1:0] round_q;
  keccak_state_t    storage_q;
  keccak_state_t    storage_d;
  keccak_state_t    step_out;

  ////////////////////////////////////////
  // Round FSM
  ////////////////////////////////////////

  assign rnd_eq_end = (round_q == rnd_w'(num_rounds - 1));

  always_comb begin
    st_d           = st_q;
    update_storage = 1'b0;
    xor_message    = 1'b0;
    rst_storage    = 1'b0;
    inc_rnd        = 1'b0;
    rst_rnd        = 1'b0;
    complete_d     = 1'b0;
    unique case (st_q)
      st_idle: begin
        if (clear_i) begin
          rst_storage = 1'b1;
        end else if (run_i) begin
          // Absorb XORs the block in, squeeze keeps the state
          st_d           = st_active;
          xor_message    = ~squeeze_i;
          update_storage = ~squeeze_i;
        end
      end
      st_active: begin
        // One round per clock
        update_storage = 1'b1;
        if (rnd_eq_end) begin
          st_d       = st_idle;
          rst_rnd    = 1'b1;
          complete_d = 1'b1;
        end else begin
          inc_rnd = 1'b1;
        end
      end
      default: st_d = st_idle;
    endcase
  end

  // New work is only taken while idle
  assign ready_o = (st_q == st_idle);

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      st_q       <= st_idle;
      round_q    <= '0;
      complete_o <= 1'b0;
    end else begin
      st_q       <= st_d;
      complete_o <= complete_d;
      if (rst_rnd) begin
        round_q <= '0;
      end else if (inc_rnd) begin
        round_q <= round_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // State storage
  ////////////////////////////////////////

  assign storage_d = xor_message ? (storage_q ^ data_i) : step_out;

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      storage_q <= '0;
    end else if (rst_storage) begin
      storage_q <= '0;
    end else if (update_storage) begin
      storage_q <= storage_d;
    end
  end

  assign state_o = storage_q;

  keccak_perm_step u_perm_step (
    .rnd_i (round_q),
    .s_i   (storage_q),
    .s_o   (step_out)
  );

endmodule

// ==== keccak_sponge_top.f ====
common/keccak_pkg.sv
keccak_round/keccak_perm_step.sv
keccak_round/keccak_round.sv
source/cmd_feeder.sv
source/digest_drain.sv
source/keccak_sponge_top.sv
tb/keccak_round_assert.sv
tb/tb_keccak_sponge.sv

// ==== source/cmd_feeder.sv ====
`timescale 1ns/1ns

module cmd_feeder (
  input  logic                      clk_i,
  input  logic                      rst_b,
  input  logic                      cmd_req_i,
  input  keccak_pkg::sponge_cmd_t   cmd_i,
  output logic                      cmd_ack_o,
  input  logic                      ready_i,
  input  logic                      drain_idle_i,
  output logic                      run_o,
  output logic                      squeeze_o,
  output logic                      clear_o,
  output keccak_pkg::keccak_state_t block_o
);
  import keccak_pkg::*;

  typedef enum logic [1:0] {
    fd_idle,
    fd_issue,
    fd_wait_release
  } feed_st_e;

  feed_st_e      st_q;
  feed_st_e      st_d;
  sponge_op_e    op_q;
  keccak_state_t block_q;
  logic          is_clear;

  assign is_clear = (op_q == op_clear);

  // Permutations also need the previous digest gone
  assign run_o   = (st_q == fd_issue) && !is_clear && ready_i && drain_idle_i;
  assign clear_o = (st_q == fd_issue) && is_clear && ready_i;

  always_comb begin
    st_d = st_q;
    unique case (st_q)
      fd_idle:         if (cmd_req_i) st_d = fd_issue;
      fd_issue:        if (run_o || clear_o) st_d = fd_wait_release;
      fd_wait_release: if (!cmd_req_i) st_d = fd_idle;
      default:         st_d = fd_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      st_q <= fd_idle;
      op_q <= op_squeeze;
    end else begin
      st_q <= st_d;
      if (st_q == fd_idle && cmd_req_i) begin
        op_q <= cmd_i.op;
      end
    end
  end

  // Block copy taken when the request is seen
  always_ff @(posedge clk_i) begin
    if (st_q == fd_idle && cmd_req_i) begin
      block_q <= cmd_i.block;
    end
  end

  assign squeeze_o = (op_q == op_squeeze);
  assign block_o   = block_q;
  // Ack held until the host drops req
  assign cmd_ack_o = (st_q == fd_wait_release);

endmodule

// ==== source/digest_drain.sv ====
`timescale 1ns/1ns

module digest_drain #(
  parameter int DigestLanes = 4
) (
  input  logic                                       clk_i,
  input  logic                                       rst_b,
  input  logic                                       complete_i,
  input  keccak_pkg::keccak_state_t                  state_i,
  output logic                                       drain_idle_o,
  output logic                                       dig_req_o,
  output logic [DigestLanes*keccak_pkg::lane_w-1:0]  dig_o,
  input  logic                                       dig_ack_i
);
  import keccak_pkg::*;

  localparam int dig_w = DigestLanes * lane_w;

  typedef enum logic [1:0] {
    dr_idle,
    dr_req,
    dr_ack_low
  } drain_st_e;

  drain_st_e        st_q;
  drain_st_e        st_d;
  logic [dig_w-1:0] dig_q;

  always_comb begin
    st_d = st_q;
    unique case (st_q)
      dr_idle:    if (complete_i) st_d = dr_req;
      dr_req:     if (dig_ack_i) st_d = dr_ack_low;
      dr_ack_low: if (!dig_ack_i) st_d = dr_idle;
      default:    st_d = dr_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      st_q <= dr_idle;
    end else begin
      st_q <= st_d;
    end
  end

  // Leading lanes, lane 0 in the low byte
  always_ff @(posedge clk_i) begin
    if (st_q == dr_idle && complete_i) begin
      dig_q <= state_i[dig_w-1:0];
    end
  end

  assign dig_o     = dig_q;
  assign dig_req_o = (st_q == dr_req);
  // Busy already in the complete cycle so no run slips in
  assign drain_idle_o = (st_q == dr_idle) && !complete_i;

endmodule

// ==== source/keccak_sponge_top.sv ====
`timescale 1ns/1ns

module keccak_sponge_top #(
  parameter int DigestLanes = 4
) (
  input  logic                                      clk_i,
  input  logic                                      rst_b,
  input  logic                                      cmd_req_i,
  input  keccak_pkg::sponge_cmd_t                   cmd_i,
  output logic                                      cmd_ack_o,
  output logic                                      dig_req_o,
  output logic [DigestLanes*keccak_pkg::lane_w-1:0] dig_o,
  input  logic                                      dig_ack_i
);
  import keccak_pkg::*;

  // Feeder to round core
  logic          run;
  logic          squeeze;
  logic          clear;
  keccak_state_t block;
  logic          ready;

  // Round core to drain, and back-pressure to the feeder
  logic          complete;
  keccak_state_t state;
  logic          drain_idle;

  cmd_feeder u_cmd_feeder (
    .clk_i        (clk_i),
    .rst_b        (rst_b),
    .cmd_req_i    (cmd_req_i),
    .cmd_i        (cmd_i),
    .cmd_ack_o    (cmd_ack_o),
    .ready_i      (ready),
    .drain_idle_i (drain_idle),
    .run_o        (run),
    .squeeze_o    (squeeze),
    .clear_o      (clear),
    .block_o      (block)
  );

  keccak_round u_keccak_round (
    .clk_i      (clk_i),
    .rst_b      (rst_b),
    .run_i      (run),
    .squeeze_i  (squeeze),
    .clear_i    (clear),
    .data_i     (block),
    .ready_o    (ready),
    .complete_o (complete),
    .state_o    (state)
  );

  digest_drain #(
    .DigestLanes (DigestLanes)
  ) u_digest_drain (
    .clk_i        (clk_i),
    .rst_b        (rst_b),
    .complete_i   (complete),
    .state_i      (state),
    .drain_idle_o (drain_idle),
    .dig_req_o    (dig_req_o),
    .dig_o        (dig_o),
    .dig_ack_i    (dig_ack_i)
  );

endmodule

// ==== tb/keccak_round_assert.sv ====
`timescale 1ns/1ns

module keccak_round_assert (
  input logic clk_i,
  input logic rst_b,
  input logic run_i,
  input logic clear_i,
  input logic ready_o,
  input logic complete_o
);

  // Run only accepted in idle
  assert property (@(posedge clk_i) disable iff (!rst_b) run_i |-> ready_o)
    else $error("run_i while round core busy");

  // Eighteen quiet cycles, then complete
  assert property (@(posedge clk_i) disable iff (!rst_b)
                   run_i |=> !complete_o [*18] ##1 complete_o)
    else $error("complete_o not 19 cycles after run_i");

  assert property (@(posedge clk_i) disable iff (!rst_b) !(run_i && clear_i))
    else $error("run_i and clear_i together");

endmodule

bind keccak_round keccak_round_assert u_round_assert (
  .clk_i      (clk_i),
  .rst_b      (rst_b),
  .run_i      (run_i),
  .clear_i    (clear_i),
  .ready_o    (ready_o),
  .complete_o (complete_o)
);

// ==== tb/keccak_tests.txt ====
# op (0 absorb, 1 squeeze, 2 clear), block hex (200 bits)
# last column: line index whose digest this one must repeat, -1 for none
2 00000000000000000000000000000000000000000000000000 -1
1 00000000000000000000000000000000000000000000000000 -1
2 00000000000000000000000000000000000000000000000000 -1
0 0123456789abcdef0123456789abcdef0123456789abcdef01 -1
0 fedcba9876543210fedcba9876543210fedcba9876543210fe -1
1 00000000000000000000000000000000000000000000000000 -1
2 00000000000000000000000000000000000000000000000000 -1
1 00000000000000000000000000000000000000000000000000 1
0 00000000000000000000000000000000000000000000000080 -1
0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 -1
1 00000000000000000000000000000000000000000000000000 -1
2 00000000000000000000000000000000000000000000000000 -1
0 0123456789abcdef0123456789abcdef0123456789abcdef01 3
1 00000000000000000000000000000000000000000000000000 -1

// ==== tb/tb_keccak_sponge.sv ====
`timescale 1ns/1ns

module tb_keccak_sponge;
  import keccak_pkg::*;

  localparam int DigestLanes = 4;
  localparam int dig_w       = DigestLanes * lane_w;
  localparam int max_tests   = 64;

  logic              clk_i;
  logic              rst_b;
  logic              cmd_req_i;
  sponge_cmd_t       cmd_i;
  logic              cmd_ack_o;
  logic              dig_req_o;
  logic [dig_w-1:0]  dig_o;
  logic              dig_ack_i;

  // Test table from the data file
  int                n_tests;
  int                t_op    [max_tests];
  keccak_state_t     t_block [max_tests];
  int                t_same  [max_tests];

  // Expected digests per line and those still in flight
  logic [dig_w-1:0]  exp_dig   [max_tests];
  logic [dig_w-1:0]  exp_dig_q [$];
  int                n_perm;
  int                n_dig_done;
  integer            seed;

  // Reference model tables built from the Keccak definition
  int                rho_tab [5][5];
  logic [lane_w-1:0] rc_tab  [num_rounds];
  keccak_state_t     model_st;

  keccak_sponge_top #(.DigestLanes(DigestLanes)) dut0 (
    .clk_i     (clk_i),
    .rst_b     (rst_b),
    .cmd_req_i (cmd_req_i),
    .cmd_i     (cmd_i),
    .cmd_ack_o (cmd_ack_o),
    .dig_req_o (dig_req_o),
    .dig_o     (dig_o),
    .dig_ack_i (dig_ack_i)
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // LFSR x^8+x^6+x^5+x^4+1 with bit 0 as the output
  function automatic logic lfsr_bit(input int t);
    logic [8:0] r;
    int         n;
    r = 9'b1;
    n = t % 255;
    for (int i = 1; i <= n; i++) begin
      r = {r[7:0], 1'b0};
      r[0] ^= r[8];
      r[4] ^= r[8];
      r[5] ^= r[8];
      r[6] ^= r[8];
    end
    return r[0];
  endfunction

  function automatic logic [lane_w-1:0] rotl8(input logic [lane_w-1:0] v, input int n);
    int k;
    k = n % lane_w;
    return (k == 0) ? v : ((v << k) | (v >> (lane_w - k)));
  endfunction

  task automatic build_tables();
    int x;
    int y;
    int tmp;
    rho_tab[0][0] = 0;
    x = 1;
    y = 0;
    // Walk of the rho offsets along (x,y) -> (y, 2x+3y)
    for (int t = 0; t < 24; t++) begin
      rho_tab[x][y] = ((t + 1) * (t + 2) / 2) % lane_w;
      tmp = y;
      y = (2 * x + 3 * y) % 5;
      x = tmp;
    end
    for (int ir = 0; ir < num_rounds; ir++) begin
      rc_tab[ir] = '0;
      for (int j = 0; j <= 3; j++) begin
        rc_tab[ir][(1 << j) - 1] = lfsr_bit(j + 7 * ir);
      end
    end
  endtask

  function automatic keccak_state_t permute(input keccak_state_t s);
    logic [lane_w-1:0] a [5][5];
    logic [lane_w-1:0] b [5][5];
    logic [lane_w-1:0] c [5];
    logic [lane_w-1:0] d [5];
    keccak_state_t     r;
    for (int i = 0; i < 25; i++) begin
      a[i % 5][i / 5] = s[lane_w*i +: lane_w];
    end
    for (int ir = 0; ir < num_rounds; ir++) begin
      for (int x = 0; x < 5; x++) begin
        c[x] = a[x][0] ^ a[x][1] ^ a[x][2] ^ a[x][3] ^ a[x][4];
      end
      for (int x = 0; x < 5; x++) begin
        d[x] = c[(x + 4) % 5] ^ rotl8(c[(x + 1) % 5], 1);
      end
      for (int x = 0; x < 5; x++) begin
        for (int y = 0; y < 5; y++) begin
          b[y][(2 * x + 3 * y) % 5] = rotl8(a[x][y] ^ d[x], rho_tab[x][y]);
        end
      end
      for (int x = 0; x < 5; x++) begin
        for (int y = 0; y < 5; y++) begin
          a[x][y] = b[x][y] ^ (~b[(x + 1) % 5][y] & b[(x + 2) % 5][y]);
        end
      end
      a[0][0] ^= rc_tab[ir];
    end
    for (int i = 0; i < 25; i++) begin
      r[lane_w*i +: lane_w] = a[i % 5][i / 5];
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_digest(input string name, input logic [dig_w-1:0] got,
                              input logic [dig_w-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic load_tests();
    int    fd;
    string line;
    int    op_v;
    int    same_v;
    keccak_state_t blk;
    n_tests = 0;
    fd = $fopen("tb/keccak_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test data file");
      $display("=== FAIL ===");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 2 && line[0] != "#") begin
        if ($sscanf(line, "%d %h %d", op_v, blk, same_v) == 3) begin
          t_op[n_tests]    = op_v;
          t_block[n_tests] = blk;
          t_same[n_tests]  = same_v;
          n_tests++;
        end
      end
    end
    $fclose(fd);
    if (n_tests == 0) begin
      $display("The test data file holds no commands");
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // Host command side
  ////////////////////////////////////////

  task automatic send_cmd(input int idx);
    @(posedge clk_i);
    cmd_i.op    <= sponge_op_e'(t_op[idx]);
    cmd_i.block <= t_block[idx];
    cmd_req_i   <= 1'b1;
    do @(negedge clk_i); while (!cmd_ack_o);
    // Previous digest must be fully handed out before a permute is acked
    if (t_op[idx] != int'(op_clear) && n_dig_done != n_perm - 1) begin
      $display("cmd_ack_o rose before the previous digest handshake finished");
      $display("=== FAIL ===");
      $fatal(1);
    end
    @(posedge clk_i);
    cmd_req_i <= 1'b0;
    do @(negedge clk_i); while (cmd_ack_o);
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_b       = 1'b0;
    cmd_req_i   = 1'b0;
    cmd_i       = '0;
    dig_ack_i   = 1'b0;
    n_perm      = 0;
    n_dig_done  = 0;
    seed        = 32'h385e;
    model_st    = '0;
    build_tables();
    load_tests();
    repeat (16) @(posedge clk_i);
    rst_b <= 1'b1;
    @(negedge clk_i);
    check_bit("cmd_ack_o", cmd_ack_o, 1'b0);
    check_bit("dig_req_o", dig_req_o, 1'b0);
    for (int i = 0; i < n_tests; i++) begin
      case (t_op[i])
        0: model_st = permute(model_st ^ t_block[i]);
        1: model_st = permute(model_st);
        default: model_st = '0;
      endcase
      if (t_op[i] != int'(op_clear)) begin
        // A line tied to an earlier one expects that digest again
        if (t_same[i] >= 0) begin
          exp_dig[i] = exp_dig[t_same[i]];
        end else begin
          exp_dig[i] = model_st[dig_w-1:0];
        end
        exp_dig_q.push_back(exp_dig[i]);
        n_perm++;
      end
      send_cmd(i);
    end
    wait (n_dig_done == n_perm);
    $display("=== PASS ===");
    $finish;
  end

  ////////////////////////////////////////
  // Digest side and watchdog
  ////////////////////////////////////////

  initial begin
    int delay;
    wait (rst_b === 1'b1);
    forever begin
      do @(negedge clk_i); while (!dig_req_o);
      if (exp_dig_q.size() == 0) begin
        $display("Digest request arrived with no permute outstanding");
        $display("=== FAIL ===");
        $fatal(1);
      end
      check_digest("dig_o", dig_o, exp_dig_q.pop_front());
      // Random hold-off keeps the next command stalled
      delay = ($random(seed) & 32'h7fff_ffff) % 31;
      repeat (delay) @(posedge clk_i);
      @(posedge clk_i);
      dig_ack_i <= 1'b1;
      do @(negedge clk_i); while (dig_req_o);
      @(posedge clk_i);
      dig_ack_i <= 1'b0;
      n_dig_done++;
    end
  end

  initial begin
    wait (n_tests > 0);
    repeat (n_tests * 60 + 16 + 20) @(posedge clk_i);
    $display("Simulation timed out before all commands finished");
    $display("=== FAIL ===");
    $fatal(1);
  end

endmodule
